// File: design/rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

	// data and address width
	localparam int XLEN = 32;
	// register index width
	localparam int REG_W = 5;
	// first fetch address after reset
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
	// sequential fetch step in bytes
	localparam logic [XLEN-1:0] PC_STEP = 32'd4;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	// alu function, roughly {instr[30], funct3}
	// sub also serves beq and bne, slt/sltu serve blt/bltu
	typedef enum logic [3:0] {
		ALU_ADD  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_SLT  = 4'b0010,
		ALU_SLTU = 4'b0011,
		ALU_XOR  = 4'b0100,
		ALU_SRL  = 4'b0101,
		ALU_OR   = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_SUB  = 4'b1000,
		ALU_BGE  = 4'b1001,
		ALU_BGEU = 4'b1010,
		ALU_SRA  = 4'b1101
	} alu_fn_e;

	// which unit feeds write back
	typedef enum logic [2:0] {
		FN_ALU    = 3'b000,
		FN_PC4    = 3'b001,
		FN_MULDIV = 3'b010,
		FN_IMM    = 3'b011,
		FN_AUIPC  = 3'b100,
		FN_LOAD   = 3'b111
	} fn_sel_e;

	// memory operation, stores have bit 3 set
	typedef enum logic [3:0] {
		MEM_NONE = 4'b0000,
		MEM_LB   = 4'b0001,
		MEM_LH   = 4'b0010,
		MEM_LW   = 4'b0011,
		MEM_LBU  = 4'b0100,
		MEM_LHU  = 4'b0101,
		MEM_SB   = 4'b1110,
		MEM_SH   = 4'b1111,
		MEM_SW   = 4'b1000
	} mem_op_e;

	// mul/div op, note div/divu and rem/remu pairs are swapped vs funct3
	typedef enum logic [2:0] {
		MD_MUL    = 3'b000,
		MD_MULH   = 3'b001,
		MD_MULHSU = 3'b010,
		MD_MULHU  = 3'b011,
		MD_DIV    = 3'b101,
		MD_DIVU   = 3'b100,
		MD_REM    = 3'b111,
		MD_REMU   = 3'b110
	} muldiv_e;

	// operand b source
	typedef enum logic [1:0] {
		B_REG   = 2'b00,
		B_IMM   = 2'b01,
		B_SHAMT = 2'b10
	} b_sel_e;

	// next pc source, resolved later in execute
	typedef enum logic [1:0] {
		PC_SEQ    = 2'b00,
		PC_TARGET = 2'b10
	} pc_sel_e;

endpackage

`default_nettype wire

// File: design/instr_fetch_wb.sv
`default_nettype none

module instr_fetch_wb (
	input  logic                           i_clk,
	input  logic                           i_reset,
	// wishbone classic master, read only
	input  logic [rv_decode_pkg::XLEN-1:0] i_wb_dat,
	input  logic                           i_wb_ack,
	output logic                           o_wb_cyc,
	output logic                           o_wb_stb,
	output logic                           o_wb_we,
	output logic [rv_decode_pkg::XLEN-1:0] o_wb_adr,
	// to decode
	input  logic                           i_decode_ready,
	output logic                           o_fetch_valid,
	output logic [rv_decode_pkg::XLEN-1:0] o_fetch_instr,
	output logic [rv_decode_pkg::XLEN-1:0] o_fetch_pc
);
	import rv_decode_pkg::*;

	// IDLE only right after reset, REQ = bus cycle open, HOLD = buffer full
	typedef enum logic [1:0] {
		IDLE,
		REQ,
		HOLD
	} fetch_state_e;

	fetch_state_e state;
	// address of the next word to fetch
	logic [XLEN-1:0] pc;
	// one word fetch buffer
	logic [XLEN-1:0] buf_instr;
	logic [XLEN-1:0] buf_pc;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state <= IDLE;
			pc    <= RESET_PC;
		end else begin
			case (state)
				// buffer empty, open the first cycle
				IDLE: state <= REQ;
				REQ: begin
					// capture on ack, cyc/stb drop on this edge
					if (i_wb_ack) begin
						state <= HOLD;
						pc    <= pc + PC_STEP;
					end
				end
				HOLD: begin
					// buffer drains this edge, next fetch may start
					if (i_decode_ready)
						state <= REQ;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// payload only, qualified by state
	always_ff @(posedge i_clk) begin
		if (state == REQ && i_wb_ack) begin
			buf_instr <= i_wb_dat;
			buf_pc    <= pc;
		end
	end

	assign o_wb_cyc      = (state == REQ);
	assign o_wb_stb      = (state == REQ);
	// fetch port never writes
	assign o_wb_we       = 1'b0;
	assign o_wb_adr      = pc;
	assign o_fetch_valid = (state == HOLD);
	assign o_fetch_instr = buf_instr;
	assign o_fetch_pc    = buf_pc;

	// cycle closes on the edge that samples ack
	a_cyc_drop_after_ack: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_wb_stb && i_wb_ack) |=> (!o_wb_cyc && !o_wb_stb));

	// request held with a stable address until the slave acks
	a_adr_stable: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr)));

endmodule

`default_nettype wire

// File: design/instr_decoder.sv
`default_nettype none

module instr_decoder (
	input  logic [rv_decode_pkg::XLEN-1:0] i_instr,
	// operand b select
	output rv_decode_pkg::b_sel_e          o_b_sel,
	// write back enable
	output logic                           o_we,
	// result unit and alu op
	output rv_decode_pkg::fn_sel_e         o_fn,
	output rv_decode_pkg::alu_fn_e         o_alu_fn,
	// branch and jump flags
	output logic                           o_branch,
	output logic                           o_bneq,
	output logic                           o_jal,
	output logic                           o_jalr,
	output logic                           o_lui,
	output logic                           o_auipc,
	output rv_decode_pkg::mem_op_e         o_mem_op,
	output rv_decode_pkg::muldiv_e         o_muldiv_op,
	// carried down to execute until the target is known
	output rv_decode_pkg::pc_sel_e         o_pc_sel,
	output logic                           o_ecall,
	output logic                           o_uret,
	output logic                           o_sret,
	output logic                           o_mret,
	output logic                           o_illegal
);
	import rv_decode_pkg::*;

	// instruction fields
	opcode_e    opc;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [11:0] funct12;
	logic        instr_30;

	// instruction classes
	logic is_op;
	logic is_op_imm;
	logic is_load;
	logic is_store;
	logic is_branch;
	logic is_jal;
	logic is_jalr;
	logic is_lui;
	logic is_auipc;
	logic is_system;
	// M extension, funct7 = 0000001
	logic is_muldiv;
	// shift immediates use shamt
	logic is_shift_imm;

	assign opc      = opcode_e'(i_instr[6:0]);
	assign funct3   = i_instr[14:12];
	assign funct7   = i_instr[31:25];
	assign funct12  = i_instr[31:20];
	assign instr_30 = i_instr[30];

	assign is_op     = (opc == OPC_OP);
	assign is_op_imm = (opc == OPC_OP_IMM);
	assign is_load   = (opc == OPC_LOAD);
	assign is_store  = (opc == OPC_STORE);
	assign is_branch = (opc == OPC_BRANCH);
	assign is_jal    = (opc == OPC_JAL);
	assign is_jalr   = (opc == OPC_JALR);
	assign is_lui    = (opc == OPC_LUI);
	assign is_auipc  = (opc == OPC_AUIPC);
	assign is_system = (opc == OPC_SYSTEM);

	assign is_muldiv    = is_op && (funct7 == 7'b0000001);
	assign is_shift_imm = is_op_imm && (funct3[1:0] == 2'b01);

	// nothing matched
	assign o_illegal = !(is_op || is_op_imm || is_load || is_store || is_branch ||
		is_jal || is_jalr || is_lui || is_auipc || is_system);

	// alu op from {bit30, funct3}, branches map onto compare ops
	always_comb begin
		o_alu_fn = ALU_ADD;
		if (is_branch) begin
			case (funct3)
				3'b000, 3'b001: o_alu_fn = ALU_SUB;
				3'b100:         o_alu_fn = ALU_SLT;
				3'b101:         o_alu_fn = ALU_BGE;
				3'b110:         o_alu_fn = ALU_SLTU;
				3'b111:         o_alu_fn = ALU_BGEU;
				default:        o_alu_fn = ALU_ADD;
			endcase
		end else if ((is_op && !is_muldiv) || is_op_imm) begin
			case (funct3)
				// bit 30 means sub only for register ops
				3'b000:  o_alu_fn = (is_op && instr_30) ? ALU_SUB : ALU_ADD;
				3'b001:  o_alu_fn = ALU_SLL;
				3'b010:  o_alu_fn = ALU_SLT;
				3'b011:  o_alu_fn = ALU_SLTU;
				3'b100:  o_alu_fn = ALU_XOR;
				3'b101:  o_alu_fn = instr_30 ? ALU_SRA : ALU_SRL;
				3'b110:  o_alu_fn = ALU_OR;
				default: o_alu_fn = ALU_AND;
			endcase
		end
	end

	// mul/div op, mul when not M
	always_comb begin
		o_muldiv_op = MD_MUL;
		if (is_muldiv) begin
			case (funct3)
				3'b000:  o_muldiv_op = MD_MUL;
				3'b001:  o_muldiv_op = MD_MULH;
				3'b010:  o_muldiv_op = MD_MULHSU;
				3'b011:  o_muldiv_op = MD_MULHU;
				3'b100:  o_muldiv_op = MD_DIV;
				3'b101:  o_muldiv_op = MD_DIVU;
				3'b110:  o_muldiv_op = MD_REM;
				default: o_muldiv_op = MD_REMU;
			endcase
		end
	end

	// load/store width, undefined funct3 gives no access
	always_comb begin
		o_mem_op = MEM_NONE;
		if (is_load) begin
			case (funct3)
				3'b000:  o_mem_op = MEM_LB;
				3'b001:  o_mem_op = MEM_LH;
				3'b010:  o_mem_op = MEM_LW;
				3'b100:  o_mem_op = MEM_LBU;
				3'b101:  o_mem_op = MEM_LHU;
				default: o_mem_op = MEM_NONE;
			endcase
		end else if (is_store) begin
			case (funct3)
				3'b000:  o_mem_op = MEM_SB;
				3'b001:  o_mem_op = MEM_SH;
				3'b010:  o_mem_op = MEM_SW;
				default: o_mem_op = MEM_NONE;
			endcase
		end
	end

	// write back source
	always_comb begin
		if (is_load)
			o_fn = FN_LOAD;
		else if (is_muldiv)
			o_fn = FN_MULDIV;
		else if (is_jal || is_jalr)
			o_fn = FN_PC4;
		else if (is_lui)
			o_fn = FN_IMM;
		else if (is_auipc)
			o_fn = FN_AUIPC;
		else
			o_fn = FN_ALU;
	end

	// stores also need rs1 + imm for the address
	assign o_b_sel = is_shift_imm ? B_SHAMT :
		(is_op_imm || is_load || is_store || is_jalr) ? B_IMM : B_REG;

	assign o_we = !o_illegal && (is_op || is_op_imm || is_load || is_jal || is_jalr ||
		is_lui || is_auipc || is_system);

	assign o_branch = is_branch;
	assign o_bneq   = is_branch && (funct3 == 3'b001);
	assign o_jal    = is_jal;
	// jalr only with funct3 000
	assign o_jalr   = is_jalr && (funct3 == 3'b000);
	assign o_lui    = is_lui;
	assign o_auipc  = is_auipc;
	assign o_pc_sel = (is_branch || is_jal || o_jalr) ? PC_TARGET : PC_SEQ;

	// privileged ops, funct3 000 and funct12 picks which
	assign o_ecall = is_system && (funct3 == 3'b000) && (funct12 == 12'h000);
	assign o_uret  = is_system && (funct3 == 3'b000) && (funct12 == 12'h002);
	assign o_sret  = is_system && (funct3 == 3'b000) && (funct12 == 12'h102);
	assign o_mret  = is_system && (funct3 == 3'b000) && (funct12 == 12'h302);

endmodule

`default_nettype wire

// File: design/imm_gen.sv
`default_nettype none

module imm_gen (
	input  logic [rv_decode_pkg::XLEN-1:0]  i_instr,
	output logic [rv_decode_pkg::XLEN-1:0]  o_imm,
	output logic [rv_decode_pkg::REG_W-1:0] o_rs1,
	output logic [rv_decode_pkg::REG_W-1:0] o_rs2,
	output logic [rv_decode_pkg::REG_W-1:0] o_rd
);
	import rv_decode_pkg::*;

	// sign bit of every format
	logic sign;

	assign sign = i_instr[31];

	always_comb begin
		case (opcode_e'(i_instr[6:0]))
			// I type
			OPC_OP_IMM, OPC_LOAD, OPC_JALR, OPC_SYSTEM:
				o_imm = {{20{sign}}, i_instr[31:20]};
			// S type, split across rd field
			OPC_STORE:
				o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
			// B type, bit 0 always zero
			OPC_BRANCH:
				o_imm = {{19{sign}}, sign, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
			// U type, upper 20 bits
			OPC_LUI, OPC_AUIPC:
				o_imm = {i_instr[31:12], 12'b0};
			// J type
			OPC_JAL:
				o_imm = {{11{sign}}, sign, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
			// R type and unknown
			default:
				o_imm = '0;
		endcase
	end

	// register indices at fixed positions
	assign o_rs1 = i_instr[19:15];
	assign o_rs2 = i_instr[24:20];
	assign o_rd  = i_instr[11:7];

endmodule

`default_nettype wire

// File: design/decode_out_reg.sv
`default_nettype none

module decode_out_reg (
	input  logic                            i_clk,
	input  logic                            i_reset,
	// upstream handshake
	input  logic                            i_in_valid,
	output logic                            o_ready,
	// downstream handshake
	input  logic                            i_stall,
	output logic                            o_valid,
	// decoded instruction in
	input  logic [rv_decode_pkg::XLEN-1:0]  i_pc,
	input  logic [rv_decode_pkg::XLEN-1:0]  i_imm,
	input  logic [rv_decode_pkg::REG_W-1:0] i_rs1,
	input  logic [rv_decode_pkg::REG_W-1:0] i_rs2,
	input  logic [rv_decode_pkg::REG_W-1:0] i_rd,
	input  rv_decode_pkg::b_sel_e           i_b_sel,
	input  logic                            i_we,
	input  rv_decode_pkg::fn_sel_e          i_fn,
	input  rv_decode_pkg::alu_fn_e          i_alu_fn,
	input  logic                            i_branch,
	input  logic                            i_bneq,
	input  logic                            i_jal,
	input  logic                            i_jalr,
	input  logic                            i_lui,
	input  logic                            i_auipc,
	input  rv_decode_pkg::mem_op_e          i_mem_op,
	input  rv_decode_pkg::muldiv_e          i_muldiv_op,
	input  rv_decode_pkg::pc_sel_e          i_pc_sel,
	input  logic                            i_ecall,
	input  logic                            i_uret,
	input  logic                            i_sret,
	input  logic                            i_mret,
	input  logic                            i_illegal,
	// registered copy out
	output logic [rv_decode_pkg::XLEN-1:0]  o_pc,
	output logic [rv_decode_pkg::XLEN-1:0]  o_imm,
	output logic [rv_decode_pkg::REG_W-1:0] o_rs1,
	output logic [rv_decode_pkg::REG_W-1:0] o_rs2,
	output logic [rv_decode_pkg::REG_W-1:0] o_rd,
	output rv_decode_pkg::b_sel_e           o_b_sel,
	output logic                            o_we,
	output rv_decode_pkg::fn_sel_e          o_fn,
	output rv_decode_pkg::alu_fn_e          o_alu_fn,
	output logic                            o_branch,
	output logic                            o_bneq,
	output logic                            o_jal,
	output logic                            o_jalr,
	output logic                            o_lui,
	output logic                            o_auipc,
	output rv_decode_pkg::mem_op_e          o_mem_op,
	output rv_decode_pkg::muldiv_e          o_muldiv_op,
	output rv_decode_pkg::pc_sel_e          o_pc_sel,
	output logic                            o_ecall,
	output logic                            o_uret,
	output logic                            o_sret,
	output logic                            o_mret,
	output logic                            o_illegal
);

	// empty, or emptying this edge
	assign o_ready = !o_valid || !i_stall;

	always_ff @(posedge i_clk) begin
		if (i_reset)
			o_valid <= 1'b0;
		else if (o_ready)
			o_valid <= i_in_valid;
	end

	// payload moves only on an accepted word
	always_ff @(posedge i_clk) begin
		if (o_ready && i_in_valid) begin
			o_pc        <= i_pc;
			o_imm       <= i_imm;
			o_rs1       <= i_rs1;
			o_rs2       <= i_rs2;
			o_rd        <= i_rd;
			o_b_sel     <= i_b_sel;
			o_we        <= i_we;
			o_fn        <= i_fn;
			o_alu_fn    <= i_alu_fn;
			o_branch    <= i_branch;
			o_bneq      <= i_bneq;
			o_jal       <= i_jal;
			o_jalr      <= i_jalr;
			o_lui       <= i_lui;
			o_auipc     <= i_auipc;
			o_mem_op    <= i_mem_op;
			o_muldiv_op <= i_muldiv_op;
			o_pc_sel    <= i_pc_sel;
			o_ecall     <= i_ecall;
			o_uret      <= i_uret;
			o_sret      <= i_sret;
			o_mret      <= i_mret;
			o_illegal   <= i_illegal;
		end
	end

	// stalled word is held intact, nothing lost or replaced
	a_hold_on_stall: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_valid && i_stall) |=> (o_valid && $stable({o_pc, o_imm, o_rs1, o_rs2, o_rd,
		o_b_sel, o_we, o_fn, o_alu_fn, o_branch, o_bneq, o_jal, o_jalr, o_lui, o_auipc,
		o_mem_op, o_muldiv_op, o_pc_sel, o_ecall, o_uret, o_sret, o_mret, o_illegal})));

endmodule

`default_nettype wire

// File: design/rv_decode_top.sv
`default_nettype none

module rv_decode_top (
	input  logic                            i_clk,
	input  logic                            i_reset,
	input  logic                            i_stall,
	// instruction memory bus
	input  logic [rv_decode_pkg::XLEN-1:0]  i_wb_dat,
	input  logic                            i_wb_ack,
	output logic                            o_wb_cyc,
	output logic                            o_wb_stb,
	output logic                            o_wb_we,
	output logic [rv_decode_pkg::XLEN-1:0]  o_wb_adr,
	// decoded instruction
	output logic                            o_valid,
	output logic [rv_decode_pkg::XLEN-1:0]  o_pc,
	output logic [rv_decode_pkg::XLEN-1:0]  o_imm,
	output logic [rv_decode_pkg::REG_W-1:0] o_rs1,
	output logic [rv_decode_pkg::REG_W-1:0] o_rs2,
	output logic [rv_decode_pkg::REG_W-1:0] o_rd,
	output rv_decode_pkg::b_sel_e           o_b_sel,
	output logic                            o_we,
	output rv_decode_pkg::fn_sel_e          o_fn,
	output rv_decode_pkg::alu_fn_e          o_alu_fn,
	output logic                            o_branch,
	output logic                            o_bneq,
	output logic                            o_jal,
	output logic                            o_jalr,
	output logic                            o_lui,
	output logic                            o_auipc,
	output rv_decode_pkg::mem_op_e          o_mem_op,
	output rv_decode_pkg::muldiv_e          o_muldiv_op,
	output rv_decode_pkg::pc_sel_e          o_pc_sel,
	output logic                            o_ecall,
	output logic                            o_uret,
	output logic                            o_sret,
	output logic                            o_mret,
	output logic                            o_illegal
);
	import rv_decode_pkg::*;

	// fetch buffer side
	logic             fetch_valid;
	logic [XLEN-1:0]  fetch_instr;
	logic [XLEN-1:0]  fetch_pc;
	logic             decode_ready;
	// combinational decode of the buffered word
	logic [XLEN-1:0]  imm;
	logic [REG_W-1:0] rs1;
	logic [REG_W-1:0] rs2;
	logic [REG_W-1:0] rd;
	b_sel_e           dec_b_sel;
	logic             dec_we;
	fn_sel_e          dec_fn;
	alu_fn_e          dec_alu_fn;
	logic             dec_branch;
	logic             dec_bneq;
	logic             dec_jal;
	logic             dec_jalr;
	logic             dec_lui;
	logic             dec_auipc;
	mem_op_e          dec_mem_op;
	muldiv_e          dec_muldiv_op;
	pc_sel_e          dec_pc_sel;
	logic             dec_ecall;
	logic             dec_uret;
	logic             dec_sret;
	logic             dec_mret;
	logic             dec_illegal;

	instr_fetch_wb i_instr_fetch_wb (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_wb_dat       (i_wb_dat),
		.i_wb_ack       (i_wb_ack),
		.o_wb_cyc       (o_wb_cyc),
		.o_wb_stb       (o_wb_stb),
		.o_wb_we        (o_wb_we),
		.o_wb_adr       (o_wb_adr),
		.i_decode_ready (decode_ready),
		.o_fetch_valid  (fetch_valid),
		.o_fetch_instr  (fetch_instr),
		.o_fetch_pc     (fetch_pc)
	);

	instr_decoder i_instr_decoder (
		.i_instr     (fetch_instr),
		.o_b_sel     (dec_b_sel),
		.o_we        (dec_we),
		.o_fn        (dec_fn),
		.o_alu_fn    (dec_alu_fn),
		.o_branch    (dec_branch),
		.o_bneq      (dec_bneq),
		.o_jal       (dec_jal),
		.o_jalr      (dec_jalr),
		.o_lui       (dec_lui),
		.o_auipc     (dec_auipc),
		.o_mem_op    (dec_mem_op),
		.o_muldiv_op (dec_muldiv_op),
		.o_pc_sel    (dec_pc_sel),
		.o_ecall     (dec_ecall),
		.o_uret      (dec_uret),
		.o_sret      (dec_sret),
		.o_mret      (dec_mret),
		.o_illegal   (dec_illegal)
	);

	imm_gen i_imm_gen (
		.i_instr (fetch_instr),
		.o_imm   (imm),
		.o_rs1   (rs1),
		.o_rs2   (rs2),
		.o_rd    (rd)
	);

	// one cycle from buffered word to o_valid
	decode_out_reg i_decode_out_reg (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_in_valid  (fetch_valid),
		.o_ready     (decode_ready),
		.i_stall     (i_stall),
		.o_valid     (o_valid),
		.i_pc        (fetch_pc),
		.i_imm       (imm),
		.i_rs1       (rs1),
		.i_rs2       (rs2),
		.i_rd        (rd),
		.i_b_sel     (dec_b_sel),
		.i_we        (dec_we),
		.i_fn        (dec_fn),
		.i_alu_fn    (dec_alu_fn),
		.i_branch    (dec_branch),
		.i_bneq      (dec_bneq),
		.i_jal       (dec_jal),
		.i_jalr      (dec_jalr),
		.i_lui       (dec_lui),
		.i_auipc     (dec_auipc),
		.i_mem_op    (dec_mem_op),
		.i_muldiv_op (dec_muldiv_op),
		.i_pc_sel    (dec_pc_sel),
		.i_ecall     (dec_ecall),
		.i_uret      (dec_uret),
		.i_sret      (dec_sret),
		.i_mret      (dec_mret),
		.i_illegal   (dec_illegal),
		.o_pc        (o_pc),
		.o_imm       (o_imm),
		.o_rs1       (o_rs1),
		.o_rs2       (o_rs2),
		.o_rd        (o_rd),
		.o_b_sel     (o_b_sel),
		.o_we        (o_we),
		.o_fn        (o_fn),
		.o_alu_fn    (o_alu_fn),
		.o_branch    (o_branch),
		.o_bneq      (o_bneq),
		.o_jal       (o_jal),
		.o_jalr      (o_jalr),
		.o_lui       (o_lui),
		.o_auipc     (o_auipc),
		.o_mem_op    (o_mem_op),
		.o_muldiv_op (o_muldiv_op),
		.o_pc_sel    (o_pc_sel),
		.o_ecall     (o_ecall),
		.o_uret      (o_uret),
		.o_sret      (o_sret),
		.o_mret      (o_mret),
		.o_illegal   (o_illegal)
	);

endmodule

`default_nettype wire

// File: tb/wb_imem_model.sv
`default_nettype none

module wb_imem_model (
	input  logic        i_clk,
	input  logic        i_reset,
	// wishbone classic slave, reads only
	input  logic        i_cyc,
	input  logic        i_stb,
	input  logic [31:0] i_adr,
	output logic [31:0] o_dat,
	output logic        o_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	// words held, index is adr[7:2]
	localparam int DEPTH = 64;
	localparam logic [31:0] FILL = 32'h5a5a_5a5a;

	logic [31:0] mem [0:DEPTH-1];
	integer seed;
	// idle cycles left before the next ack
	integer wait_left;

	// unloaded words carry their own byte address
	initial begin
		seed = 83992;
		o_ack = 1'b0;
		o_dat = '0;
		for (int i = 0; i < DEPTH; i++)
			mem[i] = (i << 2) ^ FILL;
	end

	// past the array the whole address still picks the word
	function automatic logic [31:0] read_word(input logic [31:0] adr);
		if (adr[31:2] < DEPTH)
			return mem[adr[7:2]];
		else
			return adr ^ FILL;
	endfunction

	always @(posedge i_clk) begin
		if (i_reset) begin
			o_ack     <= 1'b0;
			wait_left <= {$random(seed)} % 4;
		end else if (o_ack) begin
			// single cycle ack, master drops stb on this edge
			o_ack     <= 1'b0;
			wait_left <= {$random(seed)} % 4;
		end else if (i_cyc && i_stb) begin
			if (wait_left == 0) begin
				o_ack <= 1'b1;
				o_dat <= read_word(i_adr);
			end else
				wait_left <= wait_left - 1;
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_rv_decode_top.sv
`default_nettype none

module tb_rv_decode_top;
	timeunit 1ns;
	timeprecision 1ps;
	import rv_decode_pkg::*;

	// stim layout, one instruction per line
	localparam int COLS = 14;
	localparam int MAX_LINES = 64;

	logic        clk;
	logic        reset;
	logic        stall;
	logic [31:0] wb_dat;
	logic        wb_ack;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [31:0] wb_adr;
	logic        valid;
	logic [31:0] pc;
	logic [31:0] imm;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [4:0]  rd;
	logic [1:0]  b_sel;
	logic        we;
	logic [2:0]  fn;
	logic [3:0]  alu_fn;
	logic        branch;
	logic        bneq;
	logic        jal;
	logic        jalr;
	logic        lui;
	logic        auipc;
	logic [3:0]  mem_op;
	logic [2:0]  muldiv_op;
	logic [1:0]  pc_sel;
	logic        ecall;
	logic        uret;
	logic        sret;
	logic        mret;
	logic        illegal;

	logic [31:0] stim [0:MAX_LINES*COLS-1];
	integer      n_lines;
	// next expected instruction
	integer      idx;
	integer      seed;
	integer      stall_left;
	integer      line_err;
	integer      tests_run;
	integer      tests_failed;
	integer      k;
	logic        reset_ok;
	// completed bus reads and bus mismatches
	integer      fetched;
	integer      bus_err;

	rv_decode_top i_rv_decode_top (
		.i_clk       (clk),
		.i_reset     (reset),
		.i_stall     (stall),
		.i_wb_dat    (wb_dat),
		.i_wb_ack    (wb_ack),
		.o_wb_cyc    (wb_cyc),
		.o_wb_stb    (wb_stb),
		.o_wb_we     (wb_we),
		.o_wb_adr    (wb_adr),
		.o_valid     (valid),
		.o_pc        (pc),
		.o_imm       (imm),
		.o_rs1       (rs1),
		.o_rs2       (rs2),
		.o_rd        (rd),
		.o_b_sel     (b_sel),
		.o_we        (we),
		.o_fn        (fn),
		.o_alu_fn    (alu_fn),
		.o_branch    (branch),
		.o_bneq      (bneq),
		.o_jal       (jal),
		.o_jalr      (jalr),
		.o_lui       (lui),
		.o_auipc     (auipc),
		.o_mem_op    (mem_op),
		.o_muldiv_op (muldiv_op),
		.o_pc_sel    (pc_sel),
		.o_ecall     (ecall),
		.o_uret      (uret),
		.o_sret      (sret),
		.o_mret      (mret),
		.o_illegal   (illegal)
	);

	wb_imem_model i_wb_imem_model (
		.i_clk   (clk),
		.i_reset (reset),
		.i_cyc   (wb_cyc),
		.i_stb   (wb_stb),
		.i_adr   (wb_adr),
		.o_dat   (wb_dat),
		.o_ack   (wb_ack)
	);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// one output field against its stim column
	task automatic check_field(input string name, input logic [31:0] got, input int col);
		logic [31:0] exp;
		exp = stim[idx*COLS + col];
		if (got !== exp) begin
			$display("error at %0t ns: instr %0d %s is %h, expected %h",
				$time, idx, name, got, exp);
			line_err++;
		end
	endtask

	task automatic check_outputs();
		logic [31:0] exp_pc;
		// sequential fetch, word n sits at RESET_PC + 4n
		exp_pc = RESET_PC + 4 * idx;
		if (pc !== exp_pc) begin
			$display("error at %0t ns: instr %0d pc is %h, expected %h", $time, idx, pc, exp_pc);
			line_err++;
		end
		check_field("imm", imm, 1);
		check_field("rs1", rs1, 2);
		check_field("rs2", rs2, 3);
		check_field("rd", rd, 4);
		check_field("b_sel", b_sel, 5);
		check_field("we", we, 6);
		check_field("fn", fn, 7);
		check_field("alu_fn", alu_fn, 8);
		check_field("mem_op", mem_op, 9);
		check_field("muldiv_op", muldiv_op, 10);
		check_field("pc_sel", pc_sel, 11);
		check_field("branch/jump flags", {branch, bneq, jal, jalr, lui, auipc}, 12);
		check_field("system flags", {ecall, uret, sret, mret, illegal}, 13);
	endtask

	// read only fetches walk forward one word per completed transfer
	task automatic check_bus();
		logic [31:0] exp_adr;
		exp_adr = RESET_PC + 4 * fetched;
		if (wb_we !== 1'b0) begin
			$display("error at %0t ns: bus we is %b, expected 0", $time, wb_we);
			bus_err++;
		end
		if (wb_stb === 1'b1) begin
			if (wb_adr !== exp_adr) begin
				$display("error at %0t ns: fetch %0d adr is %h, expected %h",
					$time, fetched, wb_adr, exp_adr);
				bus_err++;
			end
			// ack seen mid cycle closes the transfer on the next edge
			if (wb_ack === 1'b1)
				fetched++;
		end
	endtask

	// random stall bursts of 1 to 5 cycles
	task automatic drive_stall();
		if (stall_left > 0) begin
			stall = 1'b1;
			stall_left--;
		end else if ({$random(seed)} % 4 == 0) begin
			stall = 1'b1;
			stall_left = {$random(seed)} % 5;
		end else
			stall = 1'b0;
	endtask

	initial begin
		reset = 1'b1;
		stall = 1'b0;
		seed = 83992;
		stall_left = 0;
		line_err = 0;
		tests_run = 0;
		tests_failed = 0;
		idx = 0;
		fetched = 0;
		bus_err = 0;
		// unused entries keep an address tag that marks the end of the data
		for (k = 0; k < MAX_LINES*COLS; k++)
			stim[k] = 32'hbad0_0000 | k;
		$readmemh("tb/decode_stim.txt", stim);
		n_lines = 0;
		while (n_lines < MAX_LINES && stim[n_lines*COLS] !== (32'hbad0_0000 | n_lines*COLS))
			n_lines++;
		#1;
		// word of line i at byte address 4i
		for (k = 0; k < n_lines; k++)
			i_wb_imem_model.mem[k] = stim[k*COLS];
		if (n_lines == 0) begin
			$display("no instructions could be read from tb/decode_stim.txt");
			tests_run++;
			tests_failed++;
		end

		// reset held 4 cycles, bus and output must stay idle
		reset_ok = 1'b1;
		repeat (4) begin
			@(negedge clk);
			if (wb_cyc !== 1'b0 || wb_stb !== 1'b0 || valid !== 1'b0) begin
				$display("error at %0t ns: idle expected in reset, cyc %b stb %b valid %b",
					$time, wb_cyc, wb_stb, valid);
				reset_ok = 1'b0;
			end
		end
		reset = 1'b0;
		tests_run++;
		if (reset_ok)
			$display("reset state: ok");
		else begin
			$display("reset state: bus or output active");
			tests_failed++;
		end

		// outputs sampled mid cycle, stall set for the coming edge
		while (idx < n_lines) begin
			@(negedge clk);
			drive_stall();
			check_bus();
			if (valid === 1'b1) begin
				check_outputs();
				// consumed on the next rising edge
				if (!stall) begin
					tests_run++;
					if (line_err == 0)
						$display("instr %0d at pc %h: ok", idx, pc);
					else begin
						$display("instr %0d at pc %h: %0d mismatches", idx, pc, line_err);
						tests_failed++;
					end
					line_err = 0;
					idx++;
				end
			end
		end

		tests_run++;
		if (bus_err == 0)
			$display("bus fetches: %0d reads, ok", fetched);
		else begin
			$display("bus fetches: %0d mismatches", bus_err);
			tests_failed++;
		end

		@(negedge clk);
		$display("summary: %0d tests, %0d passed, %0d failed",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// ten cycles per instruction plus reset and a margin
	initial begin
		#2;
		#(n_lines * 10 * 40 + 4 * 40 + 2000);
		$display("timeout: only %0d of %0d instructions came out of the decoder", idx, n_lines);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/decode_stim.txt
// instr imm rs1 rs2 rd b_sel we fn alu_fn mem_op muldiv_op pc_sel
// ctrl={branch,bneq,jal,jalr,lui,auipc} sys={ecall,uret,sret,mret,illegal}
00500093 00000005 00 05 01 1 1 0 0 0 0 0 00 00
002081b3 00000000 01 02 03 0 1 0 0 0 0 0 00 00
40118233 00000000 03 01 04 0 1 0 8 0 0 0 00 00
402252b3 00000000 04 02 05 0 1 0 d 0 0 0 00 00
00309393 00000003 01 03 07 2 1 0 1 0 0 0 00 00
4023d413 00000402 07 02 08 2 1 0 d 0 0 0 00 00
fff47493 ffffffff 08 1f 09 1 1 0 7 0 0 0 00 00
8000e513 fffff800 01 00 0a 1 1 0 6 0 0 0 00 00
02208633 00000000 01 02 0c 0 1 2 0 0 0 0 00 00
022096b3 00000000 01 02 0d 0 1 2 0 0 1 0 00 00
0241c833 00000000 03 04 10 0 1 2 0 0 5 0 00 00
0241d8b3 00000000 03 04 11 0 1 2 0 0 4 0 00 00
0241e933 00000000 03 04 12 0 1 2 0 0 7 0 00 00
0241f9b3 00000000 03 04 13 0 1 2 0 0 6 0 00 00
00408a03 00000004 01 04 14 1 1 7 0 1 0 0 00 00
ffc11a83 fffffffc 02 1c 15 1 1 7 0 2 0 0 00 00
0081ab03 00000008 03 08 16 1 1 7 0 3 0 0 00 00
00124b83 00000001 04 01 17 1 1 7 0 4 0 0 00 00
0022dc03 00000002 05 02 18 1 1 7 0 5 0 0 00 00
002082a3 00000005 01 02 05 1 0 0 0 e 0 0 00 00
fe311d23 fffffffa 02 03 1a 1 0 0 0 f 0 0 00 00
0441a023 00000040 03 04 00 1 0 0 0 8 0 0 00 00
00208463 00000008 01 02 08 0 0 0 8 0 0 2 20 00
fe4198e3 fffffff0 03 04 11 0 0 0 8 0 0 2 30 00
0062d0e3 00000800 05 06 01 0 0 0 9 0 0 2 20 00
0020e663 0000000c 01 02 0c 0 0 0 3 0 0 2 20 00
001000ef 00000800 00 01 01 0 1 1 0 0 0 2 08 00
ffdff06f fffffffc 1f 1d 00 0 1 1 0 0 0 2 08 00
00008067 00000000 01 00 00 1 1 1 0 0 0 2 04 00
123452b7 12345000 08 03 05 0 1 3 0 0 0 0 02 00
fffff317 fffff000 1f 1f 06 0 1 4 0 0 0 0 01 00
00000073 00000000 00 00 00 0 1 0 0 0 0 0 00 10
00200073 00000002 00 02 00 0 1 0 0 0 0 0 00 08
10200073 00000102 00 02 00 0 1 0 0 0 0 0 00 04
30200073 00000302 00 02 00 0 1 0 0 0 0 0 00 02
0000007f 00000000 00 00 00 0 0 0 0 0 0 0 00 01
ffffffff 00000000 1f 1f 1f 0 0 0 0 0 0 0 00 01

// File: rv_decode_top.f
design/rv_decode_pkg.sv
design/instr_fetch_wb.sv
design/instr_decoder.sv
design/imm_gen.sv
design/decode_out_reg.sv
design/rv_decode_top.sv
tb/wb_imem_model.sv
tb/tb_rv_decode_top.sv
